/* sources.f */
+incdir+.
tcb_pkg.sv
tcb_logsize2byteena.sv
tcb_mem.sv
tcb_top.sv
tcb_tb_clk.sv
tcb_checker.sv
tcb_tb.sv

/* Makefile */
# Verilator build and run of the TCB subsystem testbench

VERILATOR ?= verilator
TOP       := tcb_tb
FILELIST  := sources.f
FLAGS     := --binary --timing --assert
RUN_FLAGS := +verilator+error+limit+1000
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard *.svh)
PASS_MSG  := *** TEST PASSED ***

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* tcb_tb.sv */
/*
 * TCB subsystem testbench
 * directed transfers against a byte reference model,
 * random stall patterns and out of range accesses
 */

`timescale 1ns/1ps
`default_nettype none

`include "tcb_defs.svh"

module tcb_tb
  import tcb_pkg::*;
();

  localparam int unsigned CLK_PERIOD  = 40;
  localparam int unsigned DRV_DLY     = 2;
  // from drive time to mid cycle
  localparam int unsigned HALF_DLY    = CLK_PERIOD / 2 - DRV_DLY;
  localparam int unsigned MEM_BYTES   = `TCB_MEM_WORDS * `TCB_BEN;
  localparam int unsigned IDX_W       = $clog2(MEM_BYTES);
  localparam int unsigned LANE_W      = `TCB_MAX;
  localparam int unsigned RAND_XFERS  = 1000;
  // about 1200 transfers, stalls add up to 60 percent
  localparam int unsigned TIMEOUT_CYC = 4000;

  logic                     clk;
  logic                     rst;
  logic                     stall;
  logic                     vld;
  logic                     wen;
  logic [`TCB_ADR_W-1:0]    adr;
  tcb_siz_t                 siz;
  tcb_ndn_t                 ndn;
  tcb_byte_t [`TCB_BEN-1:0] wdt;
  logic                     rdy;
  tcb_byte_t [`TCB_BEN-1:0] rdt;
  tcb_sts_t                 sts;

  // byte addressed reference memory
  tcb_byte_t   ref_mem [MEM_BYTES];
  logic [31:0] lcg_state = 32'hd0a2ab31;
  // stall when the top LCG nibble is below this
  int unsigned stall_thr = 0;
  int unsigned err_cnt   = 0;
  int unsigned xfer_cnt  = 0;
  int unsigned hsk_cnt   = 0;
  int unsigned cyc_cnt   = 0;
  int unsigned chk_cnt;

  // response expected one cycle after the last handshake
  logic                     pend_vld = 1'b0;
  logic [`TCB_ADR_W-1:0]    pend_adr;
  tcb_sts_t                 pend_sts;
  tcb_byte_t [`TCB_BEN-1:0] pend_rdt;
  logic [`TCB_BEN-1:0]      pend_msk;

  tcb_tb_clk #(
    .PERIOD  (CLK_PERIOD),
    .RST_CYC (3)
  ) u_clk (
    .clk (clk),
    .rst (rst)
  );

  tcb_top #(
    .ALIGNED (1'b0)
  ) u_dut (
    .clk   (clk),
    .rst   (rst),
    .stall (stall),
    .vld   (vld),
    .wen   (wen),
    .adr   (adr),
    .siz   (siz),
    .ndn   (ndn),
    .wdt   (wdt),
    .rdy   (rdy),
    .rdt   (rdt),
    .sts   (sts)
  );

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] rand_word();
    return lcg_next();
  endfunction

  // random in range word with the given offset
  function automatic logic [31:0] rand_adr(input int unsigned off);
    return ((lcg_next() >> 24) & 32'hfc) | off;
  endfunction

  function automatic logic pick_stall();
    return (lcg_next() >> 28) < stall_thr;
  endfunction

  // lane that receives sub byte j
  function automatic int unsigned wr_lane(input int unsigned j, input int unsigned off,
                                          input tcb_ndn_t n);
    if (n == TCB_BIG) begin
      return (off + `TCB_BEN - j) % `TCB_BEN;
    end
    return (j + off) % `TCB_BEN;
  endfunction

  // lane that feeds sub byte i
  function automatic int unsigned rd_lane(input int unsigned i, input int unsigned off,
                                          input tcb_ndn_t n);
    if (n == TCB_BIG) begin
      return (2 * `TCB_BEN - i - off) % `TCB_BEN;
    end
    return (i + off) % `TCB_BEN;
  endfunction

  // compare the response of the previous handshake
  task automatic check_rsp();
    if (pend_vld) begin
      if (sts !== pend_sts) begin
        err_cnt++;
        $display("ERROR %0t: adr %h status %0d, expected %0d", $time, pend_adr, sts, pend_sts);
      end
      for (int unsigned i = 0; i < `TCB_BEN; i++) begin
        if (pend_msk[LANE_W'(i)] && (rdt[LANE_W'(i)] !== pend_rdt[LANE_W'(i)])) begin
          err_cnt++;
          $display("ERROR %0t: adr %h byte %0d read %h, expected %h", $time, pend_adr, i,
                   rdt[LANE_W'(i)], pend_rdt[LANE_W'(i)]);
        end
      end
      pend_vld = 1'b0;
    end
  endtask

  // one transfer, entered at drive time, left at drive time after the handshake
  task automatic do_xfer(input logic w, input logic [`TCB_ADR_W-1:0] a, input tcb_siz_t s,
                         input tcb_ndn_t n, input tcb_byte_t [`TCB_BEN-1:0] d);
    int unsigned off;
    int unsigned base;
    int unsigned nbyt;
    vld   = 1'b1;
    wen   = w;
    adr   = a;
    siz   = s;
    ndn   = n;
    wdt   = d;
    stall = pick_stall();
    // previous response is mid cycle now
    if (pend_vld) begin
      #(HALF_DLY);
      check_rsp();
    end
    @(posedge clk);
    while (!rdy) begin
      #(DRV_DLY);
      stall = pick_stall();
      @(posedge clk);
    end
    xfer_cnt++;
    off      = a % `TCB_BEN;
    base     = a - off;
    nbyt     = 1 << s;
    pend_vld = 1'b1;
    pend_adr = a;
    pend_rdt = '0;
    if (a >= MEM_BYTES) begin
      pend_sts = TCB_STS_ERR;
      pend_msk = '1;
    end else begin
      pend_sts = TCB_STS_OK;
      for (int unsigned i = 0; i < `TCB_BEN; i++) begin
        pend_msk[LANE_W'(i)] = !w && (i < nbyt);
        if (i < nbyt) begin
          pend_rdt[LANE_W'(i)] = ref_mem[IDX_W'(base + rd_lane(i, off, n))];
        end
      end
      // model follows the memory write at this edge
      if (w) begin
        for (int unsigned j = 0; j < nbyt; j++) begin
          ref_mem[IDX_W'(base + wr_lane(j, off, n))] = d[LANE_W'(j)];
        end
      end
    end
    #(DRV_DLY);
  endtask

  // drop vld for one cycle and check what is left
  task automatic go_idle();
    vld   = 1'b0;
    stall = pick_stall();
    #(HALF_DLY);
    check_rsp();
    @(posedge clk);
    #(DRV_DLY);
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic test_reset_state();
    #(HALF_DLY);
    if (sts !== TCB_STS_OK) begin
      err_cnt++;
      $display("ERROR %0t: status %0d after reset, expected ok", $time, sts);
    end
    if (rdt !== '0) begin
      err_cnt++;
      $display("ERROR %0t: read data %h after reset, expected zero", $time, rdt);
    end
    @(posedge clk);
    #(DRV_DLY);
  endtask

  // full words everywhere so the model is known
  task automatic fill_mem();
    stall_thr = 4;
    for (int unsigned w = 0; w < `TCB_MEM_WORDS; w++) begin
      do_xfer(1'b1, w * `TCB_BEN, 2'd2, TCB_LITTLE, rand_word());
    end
  endtask

  task automatic test_le_write();
    logic [`TCB_ADR_W-1:0] a;
    for (int unsigned s = 0; s < 3; s++) begin
      for (int unsigned off = 0; off < `TCB_BEN; off++) begin
        a = rand_adr(off);
        do_xfer(1'b1, a, tcb_siz_t'(s), TCB_LITTLE, rand_word());
        do_xfer(1'b0, a - off, 2'd2, TCB_LITTLE, '0);
      end
    end
  endtask

  // includes wrap around inside the word
  task automatic test_le_read();
    for (int unsigned s = 0; s < 3; s++) begin
      for (int unsigned off = 0; off < `TCB_BEN; off++) begin
        repeat (4) do_xfer(1'b0, rand_adr(off), tcb_siz_t'(s), TCB_LITTLE, '0);
      end
    end
  endtask

  task automatic test_be();
    logic [`TCB_ADR_W-1:0] a;
    for (int unsigned s = 0; s < 3; s++) begin
      for (int unsigned off = 0; off < `TCB_BEN; off++) begin
        a = rand_adr(off);
        do_xfer(1'b1, a, tcb_siz_t'(s), TCB_BIG, rand_word());
        do_xfer(1'b0, a, tcb_siz_t'(s), TCB_BIG, '0);
        do_xfer(1'b0, a - off, 2'd2, TCB_LITTLE, '0);
      end
    end
  endtask

  // low byte of each bad address aliases a real word
  task automatic test_out_of_range();
    logic [`TCB_ADR_W-1:0] bad [4] = '{32'h100, 32'h103, 32'h1000, 32'hfffffffc};
    for (int unsigned k = 0; k < 4; k++) begin
      do_xfer(1'b1, bad[k], 2'd2, TCB_LITTLE, rand_word());
      do_xfer(1'b0, bad[k], tcb_siz_t'(k % 3), tcb_ndn_t'(k[0]), '0);
      do_xfer(1'b0, bad[k] & 32'hfc, 2'd2, TCB_LITTLE, '0);
    end
  endtask

  // back to back with heavier stalls
  task automatic test_random();
    logic [31:0]           r;
    logic [`TCB_ADR_W-1:0] a;
    stall_thr = 6;
    repeat (RAND_XFERS) begin
      r = lcg_next();
      a = (r[11:8] == 4'd0) ? (32'd256 + {24'd0, r[31:24]}) : {24'd0, r[31:24]};
      do_xfer(r[0], a, (r[2:1] == 2'd3) ? 2'd2 : r[2:1], tcb_ndn_t'(r[3]), rand_word());
    end
  endtask

  //////////////////////////////////////////////////
  // monitor and watchdog
  //////////////////////////////////////////////////

  // handshakes as the stall input allows them
  always @(posedge clk) begin
    if (!rst && vld && !stall) begin
      hsk_cnt++;
    end
  end

  initial begin : watchdog
    while (cyc_cnt < TIMEOUT_CYC) begin
      @(posedge clk);
      cyc_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    stall = 1'b0;
    vld   = 1'b0;
    wen   = 1'b0;
    adr   = '0;
    siz   = 2'd0;
    ndn   = TCB_LITTLE;
    wdt   = '0;
    @(negedge rst);
    test_reset_state();
    fill_mem();
    test_le_write();
    test_le_read();
    test_be();
    test_out_of_range();
    test_random();
    go_idle();
    if (hsk_cnt != xfer_cnt) begin
      err_cnt++;
      $display("handshake count wrong: %0d handshakes for %0d requests", hsk_cnt, xfer_cnt);
    end
    chk_cnt = u_dut.u_conv.u_chk.fail_cnt;
    $display("errors: %0d checks, %0d assertions, %0d transfers", err_cnt, chk_cnt, xfer_cnt);
    if (err_cnt == 0 && chk_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule : tcb_tb

`default_nettype wire

/* tcb_checker.sv */
/*
 * TCB converter assertions
 * request stability under stall, byte enables on every
 * request and enable count matching the transfer size
 */

`timescale 1ns/1ps
`default_nettype none

`include "tcb_defs.svh"

module tcb_checker
  import tcb_pkg::*;
(
  input logic                     clk,
  input logic                     rst,
  input logic                     vld,
  input logic                     wen,
  input logic [`TCB_ADR_W-1:0]    adr,
  input tcb_siz_t                 siz,
  input tcb_ndn_t                 ndn,
  input tcb_byte_t [`TCB_BEN-1:0] wdt,
  input logic                     rdy,
  input logic                     mem_vld,
  input logic [`TCB_BEN-1:0]      mem_ben
);

  // failed assertions so far
  int unsigned fail_cnt = 0;

  // manager holds a stalled request
  a_hold: assert property (@(posedge clk) disable iff (rst)
    (vld && !rdy) |=> (vld && $stable(wen) && $stable(adr) && $stable(siz)
                       && $stable(ndn) && $stable(wdt)))
  else begin
    $error("request changed while stalled");
    fail_cnt++;
  end

  // every size maps to at least one lane
  a_ben: assert property (@(posedge clk) disable iff (rst)
    mem_vld |-> (mem_ben != '0))
  else begin
    $error("request with no byte enabled");
    fail_cnt++;
  end

  // rotation keeps exactly 2**siz lanes enabled
  a_cnt: assert property (@(posedge clk) disable iff (rst)
    mem_vld |-> ($countones(mem_ben) == (32'd1 << siz)))
  else begin
    $error("number of enabled bytes differs from the size");
    fail_cnt++;
  end

endmodule : tcb_checker

bind tcb_logsize2byteena tcb_checker u_chk (
  .clk     (clk),
  .rst     (rst),
  .vld     (vld),
  .wen     (wen),
  .adr     (adr),
  .siz     (siz),
  .ndn     (ndn),
  .wdt     (wdt),
  .rdy     (rdy),
  .mem_vld (mem_vld),
  .mem_ben (mem_ben)
);

`default_nettype wire

/* tcb_tb_clk.sv */
/*
 * TCB testbench clock and reset
 * free running clock, reset held for a few rising edges
 */

`timescale 1ns/1ps
`default_nettype none

module tcb_tb_clk #(
  parameter int unsigned PERIOD  = 40,
  parameter int unsigned RST_CYC = 3
)(
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // released just after an edge, like the other inputs
  initial begin
    rst = 1'b1;
    repeat (RST_CYC) @(posedge clk);
    #2;
    rst = 1'b0;
  end

endmodule : tcb_tb_clk

`default_nettype wire

/* tcb_top.sv */
/*
 * TCB subsystem top
 * size to byte enable converter in front of the memory
 */

`timescale 1ns/1ps
`default_nettype none

`include "tcb_defs.svh"

module tcb_top
  import tcb_pkg::*;
#(
  parameter bit ALIGNED = 1'b0
)(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          stall,
  // manager request
  input  logic                          vld,
  input  logic                          wen,
  input  logic [`TCB_ADR_W-1:0]         adr,
  input  tcb_siz_t                      siz,
  input  tcb_ndn_t                      ndn,
  input  tcb_byte_t [`TCB_BEN-1:0]      wdt,
  // handshake and response
  output logic                          rdy,
  output tcb_byte_t [`TCB_BEN-1:0]      rdt,
  output tcb_sts_t                      sts
);

  //////////////////////////////////////////////////
  // byte enable bus
  //////////////////////////////////////////////////

  logic                     mem_vld;
  logic                     mem_wen;
  logic [`TCB_ADR_W-1:0]    mem_adr;
  logic [`TCB_BEN-1:0]      mem_ben;
  tcb_byte_t [`TCB_BEN-1:0] mem_wdt;
  logic                     mem_rdy;
  tcb_byte_t [`TCB_BEN-1:0] mem_rdt;
  tcb_sts_t                 mem_sts;

  tcb_logsize2byteena #(
    .ALIGNED (ALIGNED)
  ) u_conv (
    .clk     (clk),
    .rst     (rst),
    .vld     (vld),
    .wen     (wen),
    .adr     (adr),
    .siz     (siz),
    .ndn     (ndn),
    .wdt     (wdt),
    .rdy     (rdy),
    .rdt     (rdt),
    .sts     (sts),
    .mem_vld (mem_vld),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_rdy (mem_rdy),
    .mem_rdt (mem_rdt),
    .mem_sts (mem_sts)
  );

  tcb_mem u_mem (
    .clk     (clk),
    .rst     (rst),
    .stall   (stall),
    .mem_vld (mem_vld),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_rdy (mem_rdy),
    .mem_rdt (mem_rdt),
    .mem_sts (mem_sts)
  );

endmodule : tcb_top

`default_nettype wire

/* tcb_mem.sv */
/*
 * TCB byte enable memory subordinate
 * word array written per byte lane, read data and status
 * registered at the handshake, out of range flagged as error
 */

`timescale 1ns/1ps
`default_nettype none

`include "tcb_defs.svh"

module tcb_mem
  import tcb_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  // back pressure from the testbench
  input  logic                          stall,
  // byte enable request
  input  logic                          mem_vld,
  input  logic                          mem_wen,
  input  logic [`TCB_ADR_W-1:0]         mem_adr,
  input  logic [`TCB_BEN-1:0]           mem_ben,
  input  tcb_byte_t [`TCB_BEN-1:0]      mem_wdt,
  output logic                          mem_rdy,
  // response
  output tcb_byte_t [`TCB_BEN-1:0]      mem_rdt,
  output tcb_sts_t                      mem_sts
);

  // word index width
  localparam int unsigned IDX_W = $clog2(`TCB_MEM_WORDS);

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////

  logic             hsk;
  logic             adr_ok;
  logic [IDX_W-1:0] idx;

  // storage
  tcb_byte_t [`TCB_BEN-1:0] mem_array [`TCB_MEM_WORDS];

  assign mem_rdy = ~stall;
  assign hsk     = mem_vld & mem_rdy;

  // anything above the top word is out of range
  assign adr_ok = (mem_adr >> (`TCB_MAX + IDX_W)) == '0;
  assign idx    = mem_adr[`TCB_MAX +: IDX_W];

  //////////////////////////////////////////////////
  // write
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (hsk && mem_wen && adr_ok) begin
      for (int unsigned b = 0; b < `TCB_BEN; b++) begin
        if (mem_ben[b]) begin
          mem_array[idx][b] <= mem_wdt[b];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  // held until the next handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_rdt <= '0;
      mem_sts <= TCB_STS_OK;
    end else if (hsk) begin
      // old word contents on a write
      mem_rdt <= adr_ok ? mem_array[idx] : '0;
      mem_sts <= adr_ok ? TCB_STS_OK : TCB_STS_ERR;
    end
  end

endmodule : tcb_mem

`default_nettype wire

/* tcb_logsize2byteena.sv */
/*
 * TCB logarithmic size to byte enable converter
 * rotates write data onto byte lanes, builds byte enables
 * and rotates read data back using the offset and endianness
 * registered at each handshake
 */

`timescale 1ns/1ps
`default_nettype none

`include "tcb_defs.svh"

module tcb_logsize2byteena
  import tcb_pkg::*;
#(
  // aligned variant maps better onto FPGA muxes
  parameter bit ALIGNED = 1'b0
)(
  input  logic                          clk,
  input  logic                          rst,
  // manager side, logarithmic size
  input  logic                          vld,
  input  logic                          wen,
  input  logic [`TCB_ADR_W-1:0]         adr,
  input  tcb_siz_t                      siz,
  input  tcb_ndn_t                      ndn,
  input  tcb_byte_t [`TCB_BEN-1:0]      wdt,
  output logic                          rdy,
  output tcb_byte_t [`TCB_BEN-1:0]      rdt,
  output tcb_sts_t                      sts,
  // memory side, byte enables
  output logic                          mem_vld,
  output logic                          mem_wen,
  output logic [`TCB_ADR_W-1:0]         mem_adr,
  output logic [`TCB_BEN-1:0]           mem_ben,
  output tcb_byte_t [`TCB_BEN-1:0]      mem_wdt,
  input  logic                          mem_rdy,
  input  tcb_byte_t [`TCB_BEN-1:0]      mem_rdt,
  input  tcb_sts_t                      mem_sts
);

  //////////////////////////////////////////////////
  // pass through
  //////////////////////////////////////////////////

  assign mem_vld = vld;
  assign mem_wen = wen;
  assign mem_adr = adr;

  // response side
  assign rdy = mem_rdy;
  assign sts = mem_sts;

  //////////////////////////////////////////////////
  // offset tracking
  //////////////////////////////////////////////////

  logic                hsk;
  logic [`TCB_MAX-1:0] req_off;
  logic [`TCB_MAX-1:0] rsp_off;
  // stage 0 is the live request
  logic [`TCB_MAX-1:0] off_dly [0:`TCB_HSK_DLY];

  assign hsk     = vld & rdy;
  assign req_off = adr[`TCB_MAX-1:0];

  assign off_dly[0] = req_off;

  // one stage per response delay cycle, advanced by handshakes
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int unsigned d = 1; d <= `TCB_HSK_DLY; d++) begin
        off_dly[d] <= '0;
      end
    end else if (hsk) begin
      for (int unsigned d = 1; d <= `TCB_HSK_DLY; d++) begin
        off_dly[d] <= off_dly[d-1];
      end
    end
  end

  assign rsp_off = off_dly[`TCB_HSK_DLY];

  //////////////////////////////////////////////////
  // lane multiplexers
  //////////////////////////////////////////////////

  if (ALIGNED) begin : g_aligned

    // offset bits at or above the size stay significant
    logic [`TCB_MAX-1:0] req_msk;

    // prefix OR from msb down
    function automatic logic [`TCB_MAX-1:0] prefix_or(input logic [`TCB_MAX-1:0] val);
      logic [`TCB_MAX-1:0] res;
      res[`TCB_MAX-1] = val[`TCB_MAX-1];
      for (int i = `TCB_MAX-1; i > 0; i--) begin
        res[i-1] = res[i] | val[i-1];
      end
      return res;
    endfunction

    always_comb begin
      for (int unsigned i = 0; i < `TCB_MAX; i++) begin
        req_msk[i] = (i >= siz);
      end
    end

    // byte enables and write data, little endian only
    always_comb begin
      logic [`TCB_MAX-1:0] lane;
      for (int unsigned i = 0; i < `TCB_BEN; i++) begin
        lane       = `TCB_MAX'(i);
        mem_ben[i] = (req_off & req_msk) == (lane & req_msk);
        mem_wdt[i] = wdt[lane & ~req_msk];
      end
    end

    // read data back to low bytes
    always_comb begin
      logic [`TCB_MAX-1:0] lane;
      for (int unsigned i = 0; i < `TCB_BEN; i++) begin
        lane   = `TCB_MAX'(i);
        rdt[i] = mem_rdt[(~prefix_or(lane) & rsp_off) | lane];
      end
    end

  end : g_aligned
  else begin : g_unaligned

    // enables before rotation
    logic [`TCB_BEN-1:0] sub_ben;
    // endianness pipeline, matches the offset stages
    tcb_ndn_t            ndn_dly [0:`TCB_HSK_DLY];

    assign ndn_dly[0] = ndn;

    always_ff @(posedge clk) begin
      if (rst) begin
        for (int unsigned d = 1; d <= `TCB_HSK_DLY; d++) begin
          ndn_dly[d] <= TCB_LITTLE;
        end
      end else if (hsk) begin
        for (int unsigned d = 1; d <= `TCB_HSK_DLY; d++) begin
          ndn_dly[d] <= ndn_dly[d-1];
        end
      end
    end

    // low 2**siz bytes enabled
    always_comb begin
      for (int unsigned i = 0; i < `TCB_BEN; i++) begin
        sub_ben[i] = (i < (32'd1 << siz));
      end
    end

    // modulo arithmetic comes free from the offset width
    always_comb begin
      logic [`TCB_MAX-1:0] lane;
      logic [`TCB_MAX-1:0] src;
      for (int unsigned i = 0; i < `TCB_BEN; i++) begin
        lane       = `TCB_MAX'(i);
        src        = (ndn == TCB_BIG) ? (req_off - lane) : (lane - req_off);
        mem_ben[i] = sub_ben[src];
        mem_wdt[i] = wdt[src];
      end
    end

    // read rotation with registered offset and endianness
    always_comb begin
      logic [`TCB_MAX-1:0] lane;
      logic [`TCB_MAX-1:0] sum;
      for (int unsigned i = 0; i < `TCB_BEN; i++) begin
        lane   = `TCB_MAX'(i);
        sum    = lane + rsp_off;
        rdt[i] = (ndn_dly[`TCB_HSK_DLY] == TCB_BIG) ? mem_rdt[-sum] : mem_rdt[sum];
      end
    end

  end : g_unaligned

endmodule : tcb_logsize2byteena

`default_nettype wire

/* tcb_pkg.sv */
/*
 * TCB package
 * shared bus types: endianness, transfer size,
 * response status and the data byte
 */

`default_nettype none

package tcb_pkg;

  //////////////////////////////////////////////////
  // request side types
  //////////////////////////////////////////////////

  // endianness of a transfer
  typedef enum logic {
    TCB_LITTLE = 1'b0,
    TCB_BIG    = 1'b1
  } tcb_ndn_t;

  // logarithmic transfer size
  // 0 -> 1 byte, 1 -> 2 bytes, 2 -> 4 bytes
  typedef logic [1:0] tcb_siz_t;

  //////////////////////////////////////////////////
  // response side types
  //////////////////////////////////////////////////

  // response status
  typedef enum logic {
    TCB_STS_OK  = 1'b0,
    TCB_STS_ERR = 1'b1
  } tcb_sts_t;

  //////////////////////////////////////////////////
  // data
  //////////////////////////////////////////////////

  // one byte lane, data buses are packed arrays of these
  typedef logic [7:0] tcb_byte_t;

endpackage : tcb_pkg

`default_nettype wire

/* tcb_defs.svh */
/*
 * TCB shared sizing macros
 * bus address and data width, byte offset width,
 * memory depth and handshake to response delay
 */

`ifndef TCB_DEFS_SVH
`define TCB_DEFS_SVH

//////////////////////////////////////////////////
// bus geometry
//////////////////////////////////////////////////

// byte address width
`define TCB_ADR_W 32
// bytes per data word
`define TCB_BEN 4
// width of byte offset inside a word, log2 of TCB_BEN
`define TCB_MAX 2

//////////////////////////////////////////////////
// subordinate
//////////////////////////////////////////////////

// memory depth in words, 256 bytes
`define TCB_MEM_WORDS 64
// cycles from handshake to response
`define TCB_HSK_DLY 1

`endif
